// ==== source/ahb_agent_defines.svh ====
// ahb agent bus widths, ahb transfer and response codes, reset values
`ifndef AHB_AGENT_DEFINES_SVH
`define AHB_AGENT_DEFINES_SVH

// ----------------------------------------------------------
// widths
// ----------------------------------------------------------
`define AHB_ADDR_W      32
`define AHB_DATA_W      32
`define AHB_BE_W        4
`define AHB_SIZE_W      3           // hsize field
`define PKT_ID_W        2

// ----------------------------------------------------------
// ahb and packet codes
// ----------------------------------------------------------
`define HTRANS_IDLE     2'b00
`define HTRANS_NONSEQ   2'b10

`define HRESP_OKAY      2'b00
`define HRESP_ERROR     2'b01

`define RSP_OKAY        2'b00
`define RSP_SLVERR      2'b10       // ORs cleanly over a packet

`define RESET_HSIZE     3'd2        // word

`endif

// ==== source/ahb_agent_pkg.sv ====
// ahb agent package with the data-phase record and the response beat type
`default_nettype none

`include "ahb_agent_defines.svh"

package ahb_agent_pkg;

    // ----------------------------------------------------------
    // one accepted beat, as the data phase needs it
    // ----------------------------------------------------------
    typedef struct packed {
        logic                    sop;
        logic                    eop;
        logic                    read;
        logic                    np_write;   // write, not posted
        logic [`AHB_DATA_W-1:0]  wdata;
        logic [`PKT_ID_W-1:0]    src_id;
        logic [`PKT_ID_W-1:0]    dest_id;
    } dphase_t;

    // ----------------------------------------------------------
    // one response beat
    // ----------------------------------------------------------
    typedef struct packed {
        logic                    sop;
        logic                    eop;
        logic [`AHB_DATA_W-1:0]  data;
        logic [1:0]              status;
        logic [`PKT_ID_W-1:0]    src_id;     // already swapped
        logic [`PKT_ID_W-1:0]    dest_id;
    } rsp_pkt_t;

endpackage

`default_nettype wire

// ==== source/pkt_stream_if.sv ====
// valid/ready packet stream carrying framing bits and a typed payload
`timescale 1ns/1ps
`default_nettype none

interface pkt_stream_if #(
    parameter type payload_t = logic
);

    logic     valid;
    logic     ready;
    logic     sop;
    logic     eop;
    payload_t payload;      // stable while valid && !ready

    modport source (
        output valid,
        output sop,
        output eop,
        output payload,
        input  ready
    );

    modport sink (
        input  valid,
        input  sop,
        input  eop,
        input  payload,
        output ready
    );

endinterface

`default_nettype wire

// ==== source/pkt_slot.sv ====
// one-entry registered stream buffer, generic over its payload type
`timescale 1ns/1ps
`default_nettype none

module pkt_slot #(
    parameter type payload_t = logic
) (
    input  wire logic     aclk,
    input  wire logic     aresetn,
    pkt_stream_if.sink    in,
    pkt_stream_if.source  out
);

    logic     full;
    logic     load;
    logic     sop_q;
    logic     eop_q;
    payload_t data_q;

    // room when empty, or when the head leaves this cycle
    assign in.ready = !full || out.ready;
    assign load     = in.valid && in.ready;

    always_ff @(posedge aclk or negedge aresetn) begin
        if (!aresetn) begin
            full <= 1'b0;
        end else if (load) begin
            full <= 1'b1;
        end else if (out.ready) begin
            full <= 1'b0;       // drained, nothing new
        end
    end

    // ----------------------------------------------------------
    // entry storage
    // ----------------------------------------------------------
    always_ff @(posedge aclk) begin
        if (load) begin
            sop_q  <= in.sop;
            eop_q  <= in.eop;
            data_q <= in.payload;
        end
    end

    assign out.valid   = full;      // also the busy flag seen upstream
    assign out.sop     = sop_q;
    assign out.eop     = eop_q;
    assign out.payload = data_q;

endmodule

`default_nettype wire

// ==== source/ahb_addr_phase.sv ====
// ahb address phase: command acceptance, size alignment, htrans and held address
`timescale 1ns/1ps
`default_nettype none

`include "ahb_agent_defines.svh"

module ahb_addr_phase (
    input  wire logic                     aclk,
    input  wire logic                     aresetn,
    // command beat
    input  wire logic                     cp_valid,
    output logic                          cp_ready,
    input  wire logic                     cp_sop,
    input  wire logic                     cp_eop,
    input  wire logic [`AHB_ADDR_W-1:0]   cp_addr,
    input  wire logic [`AHB_SIZE_W-1:0]   cp_size,
    input  wire logic [`AHB_BE_W-1:0]     cp_byteen,
    input  wire logic [`AHB_DATA_W-1:0]   cp_wdata,
    input  wire logic                     cp_read,
    input  wire logic                     cp_write,
    input  wire logic                     cp_posted,
    input  wire logic [`PKT_ID_W-1:0]     cp_src_id,
    input  wire logic [`PKT_ID_W-1:0]     cp_dest_id,
    // data phase status
    input  wire logic                     slot_busy,
    input  wire logic                     m0_hreadyout,
    pkt_stream_if.source                  dphase_in,
    // ahb address phase
    output logic                          m0_hsel,
    output logic [`AHB_ADDR_W-1:0]        m0_haddr,
    output logic                          m0_hwrite,
    output logic [`AHB_SIZE_W-1:0]        m0_hsize,
    output logic [1:0]                    m0_htrans
);
    import ahb_agent_pkg::*;

    logic                   run_q;
    logic                   accept;
    logic                   be_any;
    logic [`AHB_ADDR_W-1:0] size_mask;
    logic [`AHB_ADDR_W-1:0] addr_aligned;
    logic [`AHB_ADDR_W-1:0] haddr_q;
    logic                   hwrite_q;
    logic [`AHB_SIZE_W-1:0] hsize_q;
    dphase_t                rec;

    // ----------------------------------------------------------
    // acceptance
    // ----------------------------------------------------------
    always_ff @(posedge aclk or negedge aresetn) begin
        if (!aresetn) begin
            run_q <= 1'b0;
        end else begin
            run_q <= 1'b1;      // first edge after reset release
        end
    end

    // a pending data phase must end this cycle before the next address goes out
    assign cp_ready = run_q && dphase_in.ready && (!slot_busy || m0_hreadyout);
    assign accept   = cp_valid && cp_ready;

    assign size_mask    = {`AHB_ADDR_W{1'b1}} << cp_size;
    assign addr_aligned = cp_addr & size_mask;
    assign be_any       = |cp_byteen;

    // ----------------------------------------------------------
    // address phase
    // ----------------------------------------------------------
    always_ff @(posedge aclk or negedge aresetn) begin
        if (!aresetn) begin
            haddr_q  <= '0;
            hwrite_q <= 1'b0;
            hsize_q  <= `RESET_HSIZE;
        end else if (accept) begin
            haddr_q  <= addr_aligned;
            hwrite_q <= cp_write;
            hsize_q  <= cp_size;
        end
    end

    assign m0_haddr  = accept ? addr_aligned : haddr_q;
    assign m0_hwrite = accept ? cp_write : hwrite_q;
    assign m0_hsize  = accept ? cp_size : hsize_q;
    assign m0_htrans = (accept && be_any) ? `HTRANS_NONSEQ : `HTRANS_IDLE;
    assign m0_hsel   = cp_valid || slot_busy;   // stays up through the data phase

    // ----------------------------------------------------------
    // record for the data phase
    // ----------------------------------------------------------
    assign rec.sop      = cp_sop;
    assign rec.eop      = cp_eop;
    assign rec.read     = cp_read;
    assign rec.np_write = cp_write && !cp_posted;
    assign rec.wdata    = cp_wdata;
    assign rec.src_id   = cp_src_id;
    assign rec.dest_id  = cp_dest_id;

    assign dphase_in.valid   = accept;
    assign dphase_in.sop     = rec.sop;
    assign dphase_in.eop     = rec.eop;
    assign dphase_in.payload = rec;

endmodule

`default_nettype wire

// ==== source/ahb_data_phase.sv ====
// ahb data phase: write data, completion, write status merge, response filter
`timescale 1ns/1ps
`default_nettype none

`include "ahb_agent_defines.svh"

module ahb_data_phase (
    input  wire logic                     aclk,
    input  wire logic                     aresetn,
    pkt_stream_if.sink                    dphase_out,
    pkt_stream_if.source                  rsp_in,
    output logic [`AHB_DATA_W-1:0]        m0_hwdata,
    input  wire logic [`AHB_DATA_W-1:0]   m0_hrdata,
    input  wire logic [1:0]               m0_hresp,
    input  wire logic                     m0_hreadyout
);
    import ahb_agent_pkg::*;

    dphase_t                rec;
    rsp_pkt_t               rsp;
    logic                   needs_rsp;
    logic                   ahb_done;
    logic                   pop;
    logic                   held_q;
    logic [`AHB_DATA_W-1:0] rdata_q;
    logic                   err_q;
    logic                   beat_err;
    logic [`AHB_DATA_W-1:0] beat_rdata;
    logic [1:0]             beat_status;
    logic [1:0]             merged_status;
    logic [1:0]             wr_status_q;

    assign rec       = dphase_out.payload;
    assign m0_hwdata = rec.wdata;           // slot head is the beat in data phase

    // ----------------------------------------------------------
    // completion
    // ----------------------------------------------------------
    assign needs_rsp = rec.read || (rec.np_write && dphase_out.eop);
    assign ahb_done  = dphase_out.valid && (held_q || m0_hreadyout);
    assign pop       = ahb_done && (!needs_rsp || rsp_in.ready);

    assign dphase_out.ready = pop;

    // bus data phase is over but the response slot is full, keep what the slave returned
    always_ff @(posedge aclk or negedge aresetn) begin
        if (!aresetn) begin
            held_q <= 1'b0;
        end else if (pop) begin
            held_q <= 1'b0;
        end else if (ahb_done) begin
            held_q <= 1'b1;
        end
    end

    always_ff @(posedge aclk) begin
        if (ahb_done && !held_q) begin
            rdata_q <= m0_hrdata;
            err_q   <= (m0_hresp == `HRESP_ERROR);
        end
    end

    assign beat_rdata = held_q ? rdata_q : m0_hrdata;
    assign beat_err   = held_q ? err_q : (m0_hresp == `HRESP_ERROR);

    // ----------------------------------------------------------
    // write status, restarted at each sop
    // ----------------------------------------------------------
    assign beat_status   = beat_err ? `RSP_SLVERR : `RSP_OKAY;
    assign merged_status = (dphase_out.sop ? `RSP_OKAY : wr_status_q) | beat_status;

    always_ff @(posedge aclk or negedge aresetn) begin
        if (!aresetn) begin
            wr_status_q <= `RSP_OKAY;
        end else if (pop && !rec.read) begin
            wr_status_q <= merged_status;
        end
    end

    // ----------------------------------------------------------
    // response beat
    // ----------------------------------------------------------
    assign rsp.sop     = rec.read ? dphase_out.sop : dphase_out.eop;   // write rsp is a lone beat
    assign rsp.eop     = dphase_out.eop;
    assign rsp.data    = rec.read ? beat_rdata : '0;
    assign rsp.status  = rec.read ? beat_status : merged_status;
    assign rsp.src_id  = rec.dest_id;       // swapped on the way back
    assign rsp.dest_id = rec.src_id;

    assign rsp_in.valid   = ahb_done && needs_rsp;
    assign rsp_in.sop     = rsp.sop;
    assign rsp_in.eop     = rsp.eop;
    assign rsp_in.payload = rsp;

endmodule

`default_nettype wire

// ==== source/ahb_slave_agent.sv ====
// ahb slave agent top: command packets in, single ahb transfers out, responses back
`timescale 1ns/1ps
`default_nettype none

`include "ahb_agent_defines.svh"

module ahb_slave_agent (
    input  wire logic                     aclk,
    input  wire logic                     aresetn,
    // command packets
    input  wire logic                     cp_valid,
    output logic                          cp_ready,
    input  wire logic                     cp_sop,
    input  wire logic                     cp_eop,
    input  wire logic [`AHB_ADDR_W-1:0]   cp_addr,
    input  wire logic [`AHB_SIZE_W-1:0]   cp_size,
    input  wire logic [`AHB_BE_W-1:0]     cp_byteen,
    input  wire logic [`AHB_DATA_W-1:0]   cp_wdata,
    input  wire logic                     cp_read,
    input  wire logic                     cp_write,
    input  wire logic                     cp_posted,
    input  wire logic [`PKT_ID_W-1:0]     cp_src_id,
    input  wire logic [`PKT_ID_W-1:0]     cp_dest_id,
    // response packets
    output logic                          rp_valid,
    input  wire logic                     rp_ready,
    output logic                          rp_sop,
    output logic                          rp_eop,
    output logic [`AHB_DATA_W-1:0]        rp_data,
    output logic [1:0]                    rp_resp,
    output logic [`PKT_ID_W-1:0]          rp_src_id,
    output logic [`PKT_ID_W-1:0]          rp_dest_id,
    // ahb master side
    output logic                          m0_hsel,
    output logic [`AHB_ADDR_W-1:0]        m0_haddr,
    output logic                          m0_hwrite,
    output logic [1:0]                    m0_htrans,
    output logic [`AHB_SIZE_W-1:0]        m0_hsize,
    output logic [`AHB_DATA_W-1:0]        m0_hwdata,
    output logic                          m0_hreadyin,
    input  wire logic [`AHB_DATA_W-1:0]   m0_hrdata,
    input  wire logic [1:0]               m0_hresp,
    input  wire logic                     m0_hreadyout
);
    import ahb_agent_pkg::*;

    pkt_stream_if #(.payload_t(dphase_t))  dphase_in ();
    pkt_stream_if #(.payload_t(dphase_t))  dphase_out ();
    pkt_stream_if #(.payload_t(rsp_pkt_t)) rsp_in ();
    pkt_stream_if #(.payload_t(rsp_pkt_t)) rsp_out ();

    assign m0_hreadyin = m0_hreadyout;

    // ----------------------------------------------------------
    // command path
    // ----------------------------------------------------------
    ahb_addr_phase u_addr_phase (
        .aclk         (aclk),
        .aresetn      (aresetn),
        .cp_valid     (cp_valid),
        .cp_ready     (cp_ready),
        .cp_sop       (cp_sop),
        .cp_eop       (cp_eop),
        .cp_addr      (cp_addr),
        .cp_size      (cp_size),
        .cp_byteen    (cp_byteen),
        .cp_wdata     (cp_wdata),
        .cp_read      (cp_read),
        .cp_write     (cp_write),
        .cp_posted    (cp_posted),
        .cp_src_id    (cp_src_id),
        .cp_dest_id   (cp_dest_id),
        .slot_busy    (dphase_out.valid),   // beat in data phase
        .m0_hreadyout (m0_hreadyout),
        .dphase_in    (dphase_in.source),
        .m0_hsel      (m0_hsel),
        .m0_haddr     (m0_haddr),
        .m0_hwrite    (m0_hwrite),
        .m0_hsize     (m0_hsize),
        .m0_htrans    (m0_htrans)
    );

    pkt_slot #(.payload_t(dphase_t)) cmd_slot (
        .aclk    (aclk),
        .aresetn (aresetn),
        .in      (dphase_in.sink),
        .out     (dphase_out.source)
    );

    ahb_data_phase u_data_phase (
        .aclk         (aclk),
        .aresetn      (aresetn),
        .dphase_out   (dphase_out.sink),
        .rsp_in       (rsp_in.source),
        .m0_hwdata    (m0_hwdata),
        .m0_hrdata    (m0_hrdata),
        .m0_hresp     (m0_hresp),
        .m0_hreadyout (m0_hreadyout)
    );

    // ----------------------------------------------------------
    // response path
    // ----------------------------------------------------------
    pkt_slot #(.payload_t(rsp_pkt_t)) rsp_slot (
        .aclk    (aclk),
        .aresetn (aresetn),
        .in      (rsp_in.sink),
        .out     (rsp_out.source)
    );

    assign rp_valid      = rsp_out.valid;
    assign rsp_out.ready = rp_ready;
    assign rp_sop        = rsp_out.sop;
    assign rp_eop        = rsp_out.eop;
    assign rp_data       = rsp_out.payload.data;
    assign rp_resp       = rsp_out.payload.status;
    assign rp_src_id     = rsp_out.payload.src_id;
    assign rp_dest_id    = rsp_out.payload.dest_id;

endmodule

`default_nettype wire

// ==== tests/tb_checker.sv ====
// checker for the ahb slave agent that checks address phases and predicts and compares responses
`timescale 1ns/1ps
`default_nettype none

`include "ahb_agent_defines.svh"

module tb_checker (
    input  wire logic                     aclk,
    input  wire logic                     aresetn,
    input  wire logic                     cp_valid,
    input  wire logic                     cp_ready,
    input  wire logic                     cp_sop,
    input  wire logic                     cp_eop,
    input  wire logic [`AHB_ADDR_W-1:0]   cp_addr,
    input  wire logic [`AHB_SIZE_W-1:0]   cp_size,
    input  wire logic [`AHB_BE_W-1:0]     cp_byteen,
    input  wire logic                     cp_read,
    input  wire logic                     cp_write,
    input  wire logic                     cp_posted,
    input  wire logic [`PKT_ID_W-1:0]     cp_src_id,
    input  wire logic [`PKT_ID_W-1:0]     cp_dest_id,
    input  wire logic                     m0_hsel,
    input  wire logic [`AHB_ADDR_W-1:0]   m0_haddr,
    input  wire logic                     m0_hwrite,
    input  wire logic [1:0]               m0_htrans,
    input  wire logic [`AHB_SIZE_W-1:0]   m0_hsize,
    input  wire logic                     rp_valid,
    input  wire logic                     rp_ready,
    input  wire logic                     rp_sop,
    input  wire logic                     rp_eop,
    input  wire logic [`AHB_DATA_W-1:0]   rp_data,
    input  wire logic [1:0]               rp_resp,
    input  wire logic [`PKT_ID_W-1:0]     rp_src_id,
    input  wire logic [`PKT_ID_W-1:0]     rp_dest_id,
    input  wire logic [127:0]             test_name,
    input  wire logic [1:0]               exp_status,
    input  wire logic [`AHB_DATA_W-1:0]   exp_rdata,
    output int                            error_count,
    output int                            check_count,
    output int                            pending
);

    // {is_read, sop, eop, data, status, src, dest}
    logic [40:0]            exp_q [$];
    logic [127:0]           name_q [$];
    logic [40:0]            e;
    logic [127:0]           nm;
    logic [`AHB_ADDR_W-1:0] aligned;

    initial begin
        error_count = 0;
        check_count = 0;
        pending     = 0;
    end

    task automatic compare(input logic [127:0] name, input string field,
                           input logic [31:0] expv, input logic [31:0] actv);
        check_count = check_count + 1;
        if (expv !== actv) begin
            error_count = error_count + 1;
            $display("Fail %0s: %s expected %h actual %h", name, field, expv, actv);
        end
    endtask

    // values held in reset
    always @(negedge aclk) begin
        if (!aresetn) begin
            compare("reset", "rp_valid", 0, 32'(rp_valid));
            compare("reset", "cp_ready", 0, 32'(cp_ready));
            compare("reset", "hsel", 0, 32'(m0_hsel));
            compare("reset", "htrans", 32'(`HTRANS_IDLE), 32'(m0_htrans));
            compare("reset", "hsize", 32'(`RESET_HSIZE), 32'(m0_hsize));
        end
    end

    always @(posedge aclk) begin
        if (aresetn) begin
            // ----------------------------------------------------------
            // address phase in the acceptance cycle
            // ----------------------------------------------------------
            if (cp_valid && cp_ready) begin
                aligned = cp_addr & ~((32'd1 << cp_size) - 32'd1);
                if (cp_byteen != '0) begin
                    compare(test_name, "htrans", 32'(`HTRANS_NONSEQ), 32'(m0_htrans));
                    compare(test_name, "hsel", 1, 32'(m0_hsel));
                    compare(test_name, "haddr", aligned, m0_haddr);
                    compare(test_name, "hsize", 32'(cp_size), 32'(m0_hsize));
                    compare(test_name, "hwrite", 32'(cp_write), 32'(m0_hwrite));
                end else begin
                    compare(test_name, "htrans", 32'(`HTRANS_IDLE), 32'(m0_htrans));
                end
                if (cp_read) begin
                    exp_q.push_back({1'b1, cp_sop, cp_eop, exp_rdata, exp_status,
                                     cp_dest_id, cp_src_id});
                    name_q.push_back(test_name);
                end else if (!cp_posted && cp_eop) begin
                    exp_q.push_back({1'b0, 1'b1, 1'b1, 32'd0, exp_status,
                                     cp_dest_id, cp_src_id});
                    name_q.push_back(test_name);
                end
            end else begin
                compare(test_name, "htrans", 32'(`HTRANS_IDLE), 32'(m0_htrans));
            end
            // responses in command order
            if (rp_valid && rp_ready) begin
                if (exp_q.size() == 0) begin
                    error_count = error_count + 1;
                    $display("response arrived with nothing outstanding");
                end else begin
                    e  = exp_q.pop_front();
                    nm = name_q.pop_front();
                    compare(nm, "rp_sop", 32'(e[39]), 32'(rp_sop));
                    compare(nm, "rp_eop", 32'(e[38]), 32'(rp_eop));
                    compare(nm, "rp_resp", 32'(e[5:4]), 32'(rp_resp));
                    compare(nm, "rp_src_id", 32'(e[3:2]), 32'(rp_src_id));
                    compare(nm, "rp_dest_id", 32'(e[1:0]), 32'(rp_dest_id));
                    if (e[40]) begin
                        compare(nm, "rp_data", e[37:6], rp_data);
                    end
                end
            end
            pending = exp_q.size();
        end
    end

endmodule

`default_nettype wire

// ==== tests/tb_ahb_slave_agent.sv ====
// testbench top for the ahb slave agent with clock, reset, stimulus table and ahb memory slave
`timescale 1ns/1ps
`default_nettype none

`include "ahb_agent_defines.svh"

module tb_ahb_slave_agent;

    localparam int NUM_ROWS = 16;

    logic aclk;
    logic aresetn;
    logic cp_valid, cp_ready, cp_sop, cp_eop, cp_read, cp_write, cp_posted;
    logic [`AHB_ADDR_W-1:0] cp_addr;
    logic [`AHB_SIZE_W-1:0] cp_size;
    logic [`AHB_BE_W-1:0]   cp_byteen;
    logic [`AHB_DATA_W-1:0] cp_wdata;
    logic [`PKT_ID_W-1:0]   cp_src_id, cp_dest_id;
    logic rp_valid, rp_ready, rp_sop, rp_eop;
    logic [`AHB_DATA_W-1:0] rp_data;
    logic [1:0]             rp_resp;
    logic [`PKT_ID_W-1:0]   rp_src_id, rp_dest_id;
    logic m0_hsel, m0_hwrite, m0_hreadyin, m0_hreadyout;
    logic [`AHB_ADDR_W-1:0] m0_haddr;
    logic [1:0]             m0_htrans, m0_hresp;
    logic [`AHB_SIZE_W-1:0] m0_hsize;
    logic [`AHB_DATA_W-1:0] m0_hwdata, m0_hrdata;
    logic [127:0]           test_name;
    logic [1:0]             exp_status;
    logic [`AHB_DATA_W-1:0] exp_rdata;
    int                     error_count, check_count, pending;
    int                     seed;
    int                     hold_cnt;
    logic [1:0]             wait_pick;

    // stimulus table
    logic [127:0]           row_name   [NUM_ROWS];
    logic                   row_rd     [NUM_ROWS];
    logic                   row_posted [NUM_ROWS];
    logic [`AHB_ADDR_W-1:0] row_addr   [NUM_ROWS];
    logic [`AHB_SIZE_W-1:0] row_size   [NUM_ROWS];
    logic [`AHB_BE_W-1:0]   row_be     [NUM_ROWS];
    logic [`AHB_DATA_W-1:0] row_data   [NUM_ROWS];
    int                     row_len    [NUM_ROWS];
    logic [1:0]             row_status [NUM_ROWS];
    logic [`AHB_DATA_W-1:0] row_rdata  [NUM_ROWS];
    logic                   row_stall  [NUM_ROWS];

    ahb_slave_agent ahb_slave_agent_inst (.*);

    tb_checker checker_inst (.*);

    initial begin
        aclk = 1'b0;
        forever #4 aclk = ~aclk;
    end

    // ----------------------------------------------------------
    // word-memory ahb slave with random wait states
    // ----------------------------------------------------------
    logic [`AHB_DATA_W-1:0] mem [256];
    logic                   dp_active;
    logic [`AHB_ADDR_W-1:0] dp_addr;
    logic                   dp_write;
    logic [1:0]             wait_cnt;

    initial begin
        for (int i = 0; i < 256; i++) begin
            mem[i] = {8'ha5, 8'(i), ~8'(i), 8'(i) ^ 8'h3c};
        end
    end

    assign m0_hreadyout = !dp_active || (wait_cnt == 2'd0);
    assign m0_hresp     = (dp_active && m0_hreadyout && dp_addr[12]) ? `HRESP_ERROR
                                                                     : `HRESP_OKAY;
    assign m0_hrdata    = (dp_active && !dp_addr[12]) ? mem[dp_addr[9:2]] : '0;

    always @(posedge aclk or negedge aresetn) begin
        if (!aresetn) begin
            dp_active <= 1'b0;
            dp_addr   <= '0;
            dp_write  <= 1'b0;
            wait_cnt  <= 2'd0;
        end else if (m0_hreadyout) begin
            dp_active <= 1'b0;
            if (m0_hsel && m0_htrans == `HTRANS_NONSEQ && m0_hreadyin) begin
                dp_active <= 1'b1;
                dp_addr   <= m0_haddr;
                dp_write  <= m0_hwrite;
                wait_cnt  <= wait_pick;     // random stall length
            end
        end else begin
            wait_cnt <= wait_cnt - 2'd1;
        end
    end

    always @(posedge aclk) begin
        if (dp_active && m0_hreadyout && dp_write && !dp_addr[12]) begin
            mem[dp_addr[9:2]] <= m0_hwdata;     // error region drops writes
        end
    end

    // random response back-pressure and wait-state picks
    initial begin
        seed      = 43575;
        rp_ready  = 1'b0;
        wait_pick = 2'd0;
        forever begin
            @(posedge aclk);
            #2;
            wait_pick = 2'($unsigned($random(seed)) % 3);
            if (hold_cnt > 0) begin
                rp_ready = 1'b0;
                hold_cnt = hold_cnt - 1;
            end else begin
                rp_ready = ($unsigned($random(seed)) % 4) != 0;
            end
        end
    end

    task automatic set_row(input int r, input logic [127:0] nm, input logic rd,
                           input logic posted, input logic [31:0] addr, input logic [2:0] size,
                           input logic [3:0] be, input logic [31:0] data, input int len,
                           input logic [1:0] status, input logic [31:0] rdata,
                           input logic stall);
        row_name[r]   = nm;
        row_rd[r]     = rd;
        row_posted[r] = posted;
        row_addr[r]   = addr;
        row_size[r]   = size;
        row_be[r]     = be;
        row_data[r]   = data;
        row_len[r]    = len;
        row_status[r] = status;
        row_rdata[r]  = rdata;
        row_stall[r]  = stall;
    endtask

    task automatic send_beat(input int r, input int k);
        cp_valid   = 1'b1;
        cp_sop     = (k == 0);
        cp_eop     = (k == row_len[r] - 1);
        cp_addr    = row_addr[r] + 32'(4 * k);
        cp_size    = row_size[r];
        cp_byteen  = row_be[r];
        cp_wdata   = row_data[r] + 32'(k);
        cp_read    = row_rd[r];
        cp_write   = !row_rd[r];
        cp_posted  = row_posted[r];
        cp_src_id  = 2'(r);
        cp_dest_id = ~2'(r);
        test_name  = row_name[r];
        exp_status = row_status[r];
        exp_rdata  = row_rdata[r] + 32'(k);
        @(posedge aclk);
        while (!cp_ready) begin
            @(posedge aclk);
        end
        #1;
        cp_valid = 1'b0;
    endtask

    // ----------------------------------------------------------
    // table and main sequence
    // ----------------------------------------------------------
    initial begin
        aresetn    = 1'b0;
        hold_cnt   = 0;
        cp_valid   = 1'b0;
        cp_sop     = 1'b0;
        cp_eop     = 1'b0;
        cp_addr    = '0;
        cp_size    = 3'd2;
        cp_byteen  = '0;
        cp_wdata   = '0;
        cp_read    = 1'b0;
        cp_write   = 1'b0;
        cp_posted  = 1'b0;
        cp_src_id  = '0;
        cp_dest_id = '0;
        test_name  = "reset";
        exp_status = `RSP_OKAY;
        exp_rdata  = '0;
        // row name rd pst addr sz be data len status rdata stall
        set_row(0,  "wr_word",      0, 0, 32'h0010, 2, 4'hf, 32'h1111_0000, 1, `RSP_OKAY,   0, 0);
        set_row(1,  "rd_word",      1, 0, 32'h0010, 2, 4'hf, 0, 1, `RSP_OKAY, 32'h1111_0000, 0);
        set_row(2,  "wr_unal_half", 0, 0, 32'h0023, 1, 4'h3, 32'h2222_0000, 1, `RSP_OKAY,   0, 0);
        set_row(3,  "rd_unal_byte", 1, 0, 32'h0021, 0, 4'h1, 0, 1, `RSP_OKAY, 32'h2222_0000, 0);
        set_row(4,  "wr_burst",     0, 0, 32'h0040, 2, 4'hf, 32'h3333_0000, 4, `RSP_OKAY,   0, 0);
        set_row(5,  "rd_burst",     1, 0, 32'h0040, 2, 4'hf, 0, 4, `RSP_OKAY, 32'h3333_0000, 0);
        set_row(6,  "wr_err_span",  0, 0, 32'h1ffc, 2, 4'hf, 32'h4444_0000, 3, `RSP_SLVERR, 0, 0);
        set_row(7,  "rd_err",       1, 0, 32'h1004, 2, 4'hf, 0, 1, `RSP_SLVERR, 0, 0);
        set_row(8,  "wr_posted",    0, 1, 32'h0080, 2, 4'hf, 32'h5555_0000, 2, `RSP_OKAY,   0, 0);
        set_row(9,  "rd_posted",    1, 0, 32'h0080, 2, 4'hf, 0, 2, `RSP_OKAY, 32'h5555_0000, 0);
        set_row(10, "wr_zero_be",   0, 0, 32'h0010, 2, 4'h0, 32'hdead_0000, 1, `RSP_OKAY,   0, 0);
        set_row(11, "rd_after_idle", 1, 0, 32'h0010, 2, 4'hf, 0, 1, `RSP_OKAY, 32'h1111_0000, 0);
        set_row(12, "rd_stall",     1, 0, 32'h0040, 2, 4'hf, 0, 4, `RSP_OKAY, 32'h3333_0000, 1);
        set_row(13, "wr_stall",     0, 0, 32'h0090, 2, 4'hf, 32'h6666_0000, 2, `RSP_OKAY,   0, 1);
        set_row(14, "rd_stalled_wr", 1, 0, 32'h0090, 2, 4'hf, 0, 2, `RSP_OKAY, 32'h6666_0000, 0);
        set_row(15, "rd_span",      1, 0, 32'h2000, 2, 4'hf, 0, 2, `RSP_OKAY, 32'h4444_0001, 0);

        repeat (2) @(posedge aclk);
        #1;
        aresetn = 1'b1;
        @(posedge aclk);
        #1;
        for (int r = 0; r < NUM_ROWS; r++) begin
            if (row_stall[r]) begin
                hold_cnt = 16;      // rp_ready low while the row runs
            end
            for (int k = 0; k < row_len[r]; k++) begin
                send_beat(r, k);
            end
        end
        while (pending != 0) begin
            @(posedge aclk);
        end
        repeat (20) @(posedge aclk);    // room for stray responses
        $display("checks %0d, errors %0d", check_count, error_count);
        if (error_count == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

    // watchdog
    initial begin
        repeat (NUM_ROWS * 64) @(posedge aclk);
        $display("timeout: run did not finish within %0d cycles", NUM_ROWS * 64);
        $display("** FAIL **");
        $finish;
    end

endmodule

`default_nettype wire

// ==== filelist.f ====
+incdir+source
source/ahb_agent_pkg.sv
source/pkt_stream_if.sv
source/pkt_slot.sv
source/ahb_addr_phase.sv
source/ahb_data_phase.sv
source/ahb_slave_agent.sv
tests/tb_checker.sv
tests/tb_ahb_slave_agent.sv

// ==== Makefile ====
# Verilator build for the ahb slave agent

VERILATOR ?= verilator
FILELIST  ?= filelist.f
TB_TOP    ?= tb_ahb_slave_agent
RTL_TOP   ?= ahb_slave_agent
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
JOBS      ?= 0
SIM_FLAGS ?= -Wno-fatal
LINT_FLAGS ?= -Wall

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(LINT_FLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

sim:
	$(VERILATOR) --binary -j $(JOBS) $(SIM_FLAGS) --top-module $(TB_TOP) \
		-f $(FILELIST) --Mdir $(BUILD_DIR) -o sim_$(TB_TOP)
	./$(BUILD_DIR)/sim_$(TB_TOP) | tee $(LOG)
	grep -q '^\*\* PASS \*\*$$' $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
